// ==== Makefile ====
TOP = video_doubler_tb
OBJ = obj_dir

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f list.f -Mdir $(OBJ)

run: compile
	@out="$$(./$(OBJ)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ)

// ==== hw/line_buffer.sv ====
`timescale 1ns/100ps

module line_buffer (
	input  logic                         pixel_clk,
	input  logic                         wr_en,
	input  logic                         wr_bank,
	input  logic [video_pkg::H_BITS-1:0] wr_addr,
	input  video_pkg::rgb_t              wr_data,
	input  logic                         rd_bank,
	input  logic [video_pkg::H_BITS-1:0] rd_addr,
	output video_pkg::rgb_t              rd_data
);

	// Word index within one bank
	localparam int ADDR_BITS = $clog2(video_pkg::H_ACTIVE);

	////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////

	// Two banks, one line each
	video_pkg::rgb_t mem [2][video_pkg::H_ACTIVE];

	logic wr_in_range;
	logic rd_in_range;

	// Addresses past the active width fall outside the RAM
	assign wr_in_range = (wr_addr < video_pkg::H_ACTIVE);
	assign rd_in_range = (rd_addr < video_pkg::H_ACTIVE);

	////////////////////////////////////////////////////////////
	// Ports
	////////////////////////////////////////////////////////////

	// Synchronous write
	always_ff @(posedge pixel_clk) begin
		if (wr_en && wr_in_range) begin
			mem[wr_bank][wr_addr[ADDR_BITS-1:0]] <= wr_data;
		end
	end

	// Registered read, one clock latency
	// Out of range columns come back black
	always_ff @(posedge pixel_clk) begin
		if (rd_in_range) begin
			rd_data <= mem[rd_bank][rd_addr[ADDR_BITS-1:0]];
		end else begin
			rd_data <= '0;
		end
	end

endmodule

// ==== hw/pattern_source.sv ====
`timescale 1ns/100ps

module pattern_source (
	input  logic                    pixel_clk,
	input  logic                    arst_n,
	input  logic                    pixel_ce,
	input  video_pkg::timing_t      timing,
	input  logic                    cfg_req,
	input  video_pkg::pattern_cfg_t cfg,
	output logic                    cfg_ack,
	output video_pkg::video_t       video
);

	video_pkg::pattern_cfg_t active_cfg;
	video_pkg::rgb_t         pixel;
	logic                    load_point;
	logic                    checker_on;

	////////////////////////////////////////////////////////////
	// Config loader
	////////////////////////////////////////////////////////////

	// First input pixel of vertical sync, row V_ACTIVE+V_FRONT col 0
	assign load_point = pixel_ce && (timing.hcount == '0) &&
		(timing.vcount == video_pkg::V_ACTIVE + video_pkg::V_FRONT);

	// Four phase req/ack
	always_ff @(posedge pixel_clk or negedge arst_n) begin
		if (!arst_n) begin
			active_cfg.mode   <= video_pkg::MODE_GRADIENT;
			active_cfg.colour <= '0;
			cfg_ack           <= 1'b0;
		end else if (cfg_ack) begin
			// Ack held until the host lets go of req
			if (!cfg_req) begin
				cfg_ack <= 1'b0;
			end
		end else if (cfg_req && load_point) begin
			// Takes effect from the next frame on
			active_cfg <= cfg;
			cfg_ack    <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Pixel generation
	////////////////////////////////////////////////////////////

	// Odd sum of column/4 and row
	assign checker_on = timing.hcount[2] ^ timing.vcount[0];

	always_comb begin
		pixel = '0;
		if (!timing.hblank && !timing.vblank) begin
			case (active_cfg.mode)
				video_pkg::MODE_SOLID: begin
					pixel = active_cfg.colour;
				end
				video_pkg::MODE_GRADIENT: begin
					// Red ramps every 16 columns, green follows the row
					pixel.red   = timing.hcount[video_pkg::COMPONENT_DEPTH-1:0];
					pixel.green = timing.vcount;
				end
				video_pkg::MODE_CHECKER: begin
					if (checker_on) begin
						pixel = active_cfg.colour;
					end
				end
				default: begin
					pixel = '0;
				end
			endcase
		end
	end

	// One pixel per enable, lags timing by one input pixel
	always_ff @(posedge pixel_clk or negedge arst_n) begin
		if (!arst_n) begin
			video <= '0;
		end else if (pixel_ce) begin
			video.rgb    <= pixel;
			video.hsync  <= timing.hsync;
			video.vsync  <= timing.vsync;
			video.hblank <= timing.hblank;
			video.vblank <= timing.vblank;
		end
	end

	// No ack without a pending request
	ack_needs_req: assert property (
		@(posedge pixel_clk) disable iff (!arst_n)
		(!cfg_req && !cfg_ack) |=> !cfg_ack
	);

endmodule

// ==== hw/scan_doubler.sv ====
`timescale 1ns/100ps

module scan_doubler (
	input  logic              pixel_clk,
	input  logic              arst_n,
	input  logic              pixel_ce,
	input  video_pkg::video_t video_in,
	output video_pkg::video_t video_out
);

	// Output raster in output lines, twice the input rows
	localparam logic [video_pkg::V_BITS:0] OL_ACTIVE = {video_pkg::V_ACTIVE, 1'b0};
	localparam logic [video_pkg::V_BITS:0] OL_VS_START =
		{video_pkg::V_ACTIVE + video_pkg::V_FRONT, 1'b0};
	localparam logic [video_pkg::V_BITS:0] OL_VS_END =
		{video_pkg::V_ACTIVE + video_pkg::V_FRONT + video_pkg::V_SYNC, 1'b0};
	localparam logic [video_pkg::V_BITS:0] OL_LAST = {video_pkg::V_TOTAL, 1'b0} - 1'b1;
	// Pair shown while input vsync starts is the row just before it
	localparam logic [video_pkg::V_BITS:0] OL_REALIGN = OL_VS_START - 2'd2;

	logic                         prev_hblank;
	logic                         prev_vsync;
	logic                         synced;
	logic                         line_start;
	logic                         line_end;
	logic                         frame_start;
	logic                         wr_en;
	logic                         wr_bank;
	logic [video_pkg::H_BITS-1:0] wr_addr;
	logic                         running;
	logic                         rd_bank;
	logic [video_pkg::H_BITS-1:0] ocol;
	logic [video_pkg::V_BITS:0]   oline;
	logic [video_pkg::V_BITS:0]   oline_next;
	logic                         ocol_wrap;
	video_pkg::rgb_t              rd_data;
	// Control bits, {active, hsync, vsync, hblank, vblank}
	logic [4:0]                   ctl_s0;
	logic [4:0]                   ctl_s1;

	////////////////////////////////////////////////////////////
	// Input side
	////////////////////////////////////////////////////////////

	// Line edges from the input hblank, sampled at input rate
	assign line_start  = pixel_ce && !video_in.hblank && prev_hblank;
	assign line_end    = pixel_ce && video_in.hblank && !prev_hblank;
	assign frame_start = line_start && video_in.vsync && !prev_vsync;

	// Partial first line after reset is dropped
	assign wr_en = pixel_ce && synced && !video_in.hblank;

	always_ff @(posedge pixel_clk or negedge arst_n) begin
		if (!arst_n) begin
			prev_hblank <= 1'b0;
			prev_vsync  <= 1'b0;
			synced      <= 1'b0;
			wr_bank     <= 1'b0;
			wr_addr     <= '0;
		end else if (pixel_ce) begin
			prev_hblank <= video_in.hblank;
			prev_vsync  <= video_in.vsync;
			if (line_end) begin
				// Next line goes to the other bank
				synced  <= 1'b1;
				wr_bank <= ~wr_bank;
				wr_addr <= '0;
			end else if (wr_en) begin
				wr_addr <= wr_addr + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Output counters
	////////////////////////////////////////////////////////////

	assign ocol_wrap  = (ocol == video_pkg::H_TOTAL - 1'b1);
	assign oline_next = (oline == OL_LAST) ? '0 : oline + 1'b1;

	// Two output lines per input line, resynced at every input line start
	always_ff @(posedge pixel_clk or negedge arst_n) begin
		if (!arst_n) begin
			running <= 1'b0;
			rd_bank <= 1'b0;
			ocol    <= '0;
			oline   <= '0;
		end else if (line_start) begin
			running <= 1'b1;
			// Read the line just completed
			rd_bank <= ~wr_bank;
			ocol    <= '0;
			if (frame_start) begin
				oline <= OL_REALIGN;
			end else begin
				oline <= oline_next;
			end
		end else if (running) begin
			if (ocol_wrap) begin
				ocol  <= '0;
				oline <= oline_next;
			end else begin
				ocol <= ocol + 1'b1;
			end
		end
	end

	line_buffer u_line_buffer (
		.pixel_clk (pixel_clk),
		.wr_en     (wr_en),
		.wr_bank   (wr_bank),
		.wr_addr   (wr_addr),
		.wr_data   (video_in.rgb),
		.rd_bank   (rd_bank),
		.rd_addr   (ocol),
		.rd_data   (rd_data)
	);

	////////////////////////////////////////////////////////////
	// Doubled timing, two stage pipeline
	////////////////////////////////////////////////////////////

	// Stage 0, decode from the output counters
	always_comb begin
		ctl_s0 = '0;
		if (running) begin
			ctl_s0[3] = (ocol >= video_pkg::H_ACTIVE + video_pkg::H_FRONT) &&
				(ocol < video_pkg::H_ACTIVE + video_pkg::H_FRONT + video_pkg::H_SYNC);
			ctl_s0[2] = (oline >= OL_VS_START) && (oline < OL_VS_END);
			ctl_s0[1] = (ocol >= video_pkg::H_ACTIVE);
			ctl_s0[0] = (oline >= OL_ACTIVE);
			ctl_s0[4] = !ctl_s0[1] && !ctl_s0[0];
		end
	end

	// Stage 1 matches the RAM read, stage 2 is the output register
	always_ff @(posedge pixel_clk or negedge arst_n) begin
		if (!arst_n) begin
			ctl_s1    <= '0;
			video_out <= '0;
		end else begin
			ctl_s1           <= ctl_s0;
			video_out.rgb    <= ctl_s1[4] ? rd_data : '0;
			video_out.hsync  <= ctl_s1[3];
			video_out.vsync  <= ctl_s1[2];
			video_out.hblank <= ctl_s1[1];
			video_out.vblank <= ctl_s1[0];
		end
	end

	// Input lines never run past the active width
	wr_addr_in_line: assert property (
		@(posedge pixel_clk) disable iff (!arst_n)
		wr_en |-> (wr_addr < video_pkg::H_ACTIVE)
	);

endmodule

// ==== hw/video_doubler_top.sv ====
`timescale 1ns/100ps

module video_doubler_top (
	input  logic                    pixel_clk,
	input  logic                    arst_n,
	input  logic                    cfg_req,
	input  video_pkg::pattern_cfg_t cfg,
	output logic                    cfg_ack,
	output video_pkg::video_t       vid_out
);

	// Input rate enable, shared by the source and the doubler
	logic               pixel_ce;
	video_pkg::timing_t timing;
	// Board side video, half rate
	video_pkg::video_t  src_video;

	////////////////////////////////////////////////////////////
	// Input raster
	////////////////////////////////////////////////////////////

	video_timing u_timing (
		.pixel_clk (pixel_clk),
		.arst_n    (arst_n),
		.pixel_ce  (pixel_ce),
		.timing    (timing)
	);

	pattern_source u_pattern (
		.pixel_clk (pixel_clk),
		.arst_n    (arst_n),
		.pixel_ce  (pixel_ce),
		.timing    (timing),
		.cfg_req   (cfg_req),
		.cfg       (cfg),
		.cfg_ack   (cfg_ack),
		.video     (src_video)
	);

	////////////////////////////////////////////////////////////
	// Line doubled output
	////////////////////////////////////////////////////////////

	scan_doubler u_doubler (
		.pixel_clk (pixel_clk),
		.arst_n    (arst_n),
		.pixel_ce  (pixel_ce),
		.video_in  (src_video),
		.video_out (vid_out)
	);

endmodule

// ==== hw/video_pkg.sv ====
package video_pkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////

	// Bits per colour component
	localparam int COMPONENT_DEPTH = 4;

	// Column and row counter widths
	localparam int H_BITS = 6;
	localparam int V_BITS = 4;

	////////////////////////////////////////////////////////////
	// Input raster
	////////////////////////////////////////////////////////////

	// Horizontal, in input pixels
	localparam logic [H_BITS-1:0] H_ACTIVE = H_BITS'(32);
	localparam logic [H_BITS-1:0] H_FRONT  = H_BITS'(4);
	localparam logic [H_BITS-1:0] H_SYNC   = H_BITS'(6);
	localparam logic [H_BITS-1:0] H_BACK   = H_BITS'(6);
	localparam logic [H_BITS-1:0] H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

	// Vertical, in input lines
	localparam logic [V_BITS-1:0] V_ACTIVE = V_BITS'(8);
	localparam logic [V_BITS-1:0] V_FRONT  = V_BITS'(2);
	localparam logic [V_BITS-1:0] V_SYNC   = V_BITS'(2);
	localparam logic [V_BITS-1:0] V_BACK   = V_BITS'(2);
	localparam logic [V_BITS-1:0] V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

	// Pattern modes, 2'd3 reserved (black)
	localparam logic [1:0] MODE_SOLID    = 2'd0;
	localparam logic [1:0] MODE_GRADIENT = 2'd1;
	localparam logic [1:0] MODE_CHECKER  = 2'd2;

	////////////////////////////////////////////////////////////
	// Structs
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [COMPONENT_DEPTH-1:0] red;
		logic [COMPONENT_DEPTH-1:0] green;
		logic [COMPONENT_DEPTH-1:0] blue;
	} rgb_t;

	// Raster position plus decoded syncs and blanks
	typedef struct packed {
		logic [H_BITS-1:0] hcount;
		logic [V_BITS-1:0] vcount;
		logic              hsync;
		logic              vsync;
		logic              hblank;
		logic              vblank;
	} timing_t;

	typedef struct packed {
		rgb_t rgb;
		logic hsync;
		logic vsync;
		logic hblank;
		logic vblank;
	} video_t;

	typedef struct packed {
		logic [1:0] mode;
		rgb_t       colour;
	} pattern_cfg_t;

endpackage

// ==== hw/video_timing.sv ====
`timescale 1ns/100ps

module video_timing (
	input  logic               pixel_clk,
	input  logic               arst_n,
	output logic               pixel_ce,
	output video_pkg::timing_t timing
);

	logic [video_pkg::H_BITS-1:0] hcount;
	logic [video_pkg::V_BITS-1:0] vcount;
	logic                         line_end;
	logic                         frame_end;

	////////////////////////////////////////////////////////////
	// Half rate enable
	////////////////////////////////////////////////////////////

	// Low on the first clock out of reset, then toggles
	always_ff @(posedge pixel_clk or negedge arst_n) begin
		if (!arst_n) begin
			pixel_ce <= 1'b0;
		end else begin
			pixel_ce <= ~pixel_ce;
		end
	end

	////////////////////////////////////////////////////////////
	// Raster counters
	////////////////////////////////////////////////////////////

	assign line_end  = (hcount == video_pkg::H_TOTAL - 1'b1);
	assign frame_end = (vcount == video_pkg::V_TOTAL - 1'b1);

	// Column wraps at H_TOTAL, row steps on the column wrap
	always_ff @(posedge pixel_clk or negedge arst_n) begin
		if (!arst_n) begin
			hcount <= '0;
			vcount <= '0;
		end else if (pixel_ce) begin
			if (line_end) begin
				hcount <= '0;
				// Row wraps at V_TOTAL
				if (frame_end) begin
					vcount <= '0;
				end else begin
					vcount <= vcount + 1'b1;
				end
			end else begin
				hcount <= hcount + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Sync and blank decode
	////////////////////////////////////////////////////////////

	// Describes the pixel at the current count, syncs active high
	always_comb begin
		timing.hcount = hcount;
		timing.vcount = vcount;
		// Horizontal sync after the front porch
		timing.hsync  = (hcount >= video_pkg::H_ACTIVE + video_pkg::H_FRONT) &&
			(hcount < video_pkg::H_ACTIVE + video_pkg::H_FRONT + video_pkg::H_SYNC);
		// Vertical sync, whole lines
		timing.vsync  = (vcount >= video_pkg::V_ACTIVE + video_pkg::V_FRONT) &&
			(vcount < video_pkg::V_ACTIVE + video_pkg::V_FRONT + video_pkg::V_SYNC);
		// Blanks cover everything past the active area
		timing.hblank = (hcount >= video_pkg::H_ACTIVE);
		timing.vblank = (vcount >= video_pkg::V_ACTIVE);
	end

	// Enable is a single clock pulse, never two in a row
	ce_single_pulse: assert property (
		@(posedge pixel_clk) disable iff (!arst_n)
		pixel_ce |=> !pixel_ce
	);

endmodule

// ==== list.f ====
hw/video_pkg.sv
hw/line_buffer.sv
hw/video_timing.sv
hw/pattern_source.sv
hw/scan_doubler.sv
hw/video_doubler_top.sv
verification/video_doubler_tb.sv

// ==== verification/video_doubler_tb.sv ====
`timescale 1ns/100ps

module video_doubler_tb;

	////////////////////////////////////////////////////////////
	// Constants
	////////////////////////////////////////////////////////////

	localparam int          CLK_PERIOD   = 40;
	localparam int          RESET_CYCLES = 5;
	localparam logic [31:0] SEED         = 32'h0a67_c454;

	// Output raster, in clocks and output lines
	localparam int H_ACTIVE     = int'(video_pkg::H_ACTIVE);
	localparam int H_SYNC       = int'(video_pkg::H_SYNC);
	localparam int LINE_CLOCKS  = int'(video_pkg::H_TOTAL);
	localparam int ACTIVE_LINES = 2 * int'(video_pkg::V_ACTIVE);
	localparam int VSYNC_LINES  = 2 * int'(video_pkg::V_SYNC);
	localparam int OUT_LINES    = 2 * int'(video_pkg::V_TOTAL);
	// Same length as one input frame
	localparam int FRAME_CLOCKS = OUT_LINES * LINE_CLOCKS;

	// Watched bits for the edge waits
	localparam int SEL_HSYNC  = 0;
	localparam int SEL_VSYNC  = 1;
	localparam int SEL_VBLANK = 2;
	localparam int SEL_ACK    = 3;

	logic                    pixel_clk;
	logic                    arst_n;
	logic                    cfg_req;
	video_pkg::pattern_cfg_t cfg;
	logic                    cfg_ack;
	video_pkg::video_t       vid_out;

	int          error_count;
	int          errors_at_start;
	int          test_count;
	logic [31:0] rng_state;

	initial pixel_clk = 1'b0;
	always #(CLK_PERIOD / 2) pixel_clk = ~pixel_clk;

	video_doubler_top UUT (
		.pixel_clk (pixel_clk),
		.arst_n    (arst_n),
		.cfg_req   (cfg_req),
		.cfg       (cfg),
		.cfg_ack   (cfg_ack),
		.vid_out   (vid_out)
	);

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Expected active pixel, row is the input row
	function automatic video_pkg::rgb_t expected_pixel(video_pkg::pattern_cfg_t pcfg,
		int col, int row);
		video_pkg::rgb_t px;
		px = '0;
		case (pcfg.mode)
			video_pkg::MODE_SOLID: px = pcfg.colour;
			video_pkg::MODE_GRADIENT: begin
				px.red   = 4'(col % 16);
				px.green = 4'(row);
			end
			video_pkg::MODE_CHECKER: begin
				if (((col / 4) + row) % 2 == 1) begin
					px = pcfg.colour;
				end
			end
			default: px = '0;
		endcase
		return px;
	endfunction

	function automatic logic observed_bit(int sel);
		case (sel)
			SEL_HSYNC:  return vid_out.hsync;
			SEL_VSYNC:  return vid_out.vsync;
			SEL_VBLANK: return vid_out.vblank;
			default:    return cfg_ack;
		endcase
	endfunction

	// Drive and sample point, 2 ns past the rising edge
	task automatic step();
		@(posedge pixel_clk);
		#2;
	endtask

	task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual) begin
			error_count++;
			$display("error %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic finish_test(string name);
		test_count++;
		$display("test %s finished with %0d errors", name, error_count - errors_at_start);
		errors_at_start = error_count;
	endtask

	// Counted wait for the watched bit to change to level
	task automatic wait_edge(int sel, logic level, int limit, string what, output logic ok);
		logic prev;
		int   n;
		ok = 1'b0;
		n = 0;
		while (!ok && n < limit) begin
			prev = observed_bit(sel);
			step();
			n++;
			ok = (prev !== level) && (observed_bit(sel) === level);
		end
		if (!ok) begin
			error_count++;
			$display("timeout after %0d clocks waiting for %s", limit, what);
		end
	endtask

	// Whole output frame from the first active clock
	task automatic check_frame(string name, video_pkg::pattern_cfg_t pcfg);
		logic            ok;
		int              oline;
		int              ocol;
		video_pkg::rgb_t expected;
		wait_edge(SEL_VBLANK, 1'b0, 2 * FRAME_CLOCKS, "start of active video", ok);
		for (oline = 0; ok && oline < OUT_LINES; oline++) begin
			for (ocol = 0; ocol < LINE_CLOCKS; ocol++) begin
				if (oline != 0 || ocol != 0) begin
					step();
				end
				expected = '0;
				// Lines 2k and 2k+1 both show input row k
				if (oline < ACTIVE_LINES && ocol < H_ACTIVE) begin
					expected = expected_pixel(pcfg, ocol, oline / 2);
				end
				check_value($sformatf("%s line %0d col %0d rgb", name, oline, ocol),
					32'(expected), 32'(vid_out.rgb));
				check_value($sformatf("%s line %0d col %0d blanks", name, oline, ocol),
					32'({oline >= ACTIVE_LINES, ocol >= H_ACTIVE}),
					32'({vid_out.vblank, vid_out.hblank}));
			end
		end
	endtask

	// Four phase load, checks ack against req
	task automatic load_config(string name, video_pkg::pattern_cfg_t new_cfg, output logic ok);
		cfg     = new_cfg;
		cfg_req = 1'b1;
		wait_edge(SEL_ACK, 1'b1, FRAME_CLOCKS + 4, "cfg_ack to rise", ok);
		if (ok) begin
			repeat (10) begin
				step();
				check_value({name, " ack held"}, 32'd1, 32'(cfg_ack));
			end
			cfg_req = 1'b0;
			wait_edge(SEL_ACK, 1'b0, 4, "cfg_ack to fall", ok);
		end
		cfg_req = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic test_reset();
		arst_n = 1'b0;
		repeat (RESET_CYCLES) begin
			step();
			check_value("reset video", 32'd0, 32'(vid_out));
			check_value("reset cfg_ack", 32'd0, 32'(cfg_ack));
		end
		arst_n = 1'b1;
		// First clock out of reset
		step();
		check_value("reset video", 32'd0, 32'(vid_out));
		check_value("reset cfg_ack", 32'd0, 32'(cfg_ack));
		finish_test("reset");
	endtask

	task automatic test_raster();
		logic ok;
		logic prev_hs;
		logic prev_vs;
		int   clocks;
		int   last_rise;
		int   hs_width;
		int   hs_pulses;
		int   vs_lines;
		int   active_lines;
		wait_edge(SEL_VSYNC, 1'b1, 2 * FRAME_CLOCKS, "output vsync", ok);
		{clocks, hs_width, hs_pulses, vs_lines, active_lines} = '0;
		last_rise = -1;
		prev_hs   = vid_out.hsync;
		prev_vs   = vid_out.vsync;
		// One frame, vsync rise to vsync rise
		while (ok && clocks < 2 * FRAME_CLOCKS) begin
			step();
			clocks++;
			if (vid_out.hsync && !prev_hs) begin
				if (last_rise >= 0) begin
					check_value("raster hsync period", 32'(LINE_CLOCKS), 32'(clocks - last_rise));
				end
				last_rise = clocks;
				hs_pulses++;
				vs_lines += int'(vid_out.vsync);
				active_lines += int'(!vid_out.vblank);
			end
			hs_width += int'(vid_out.hsync);
			if (!vid_out.hsync && prev_hs) begin
				check_value("raster hsync width", 32'(H_SYNC), 32'(hs_width));
				hs_width = 0;
			end
			if (vid_out.vsync && !prev_vs) begin
				break;
			end
			prev_hs = vid_out.hsync;
			prev_vs = vid_out.vsync;
		end
		if (ok && clocks >= 2 * FRAME_CLOCKS) begin
			error_count++;
			$display("raster frame never ended, no second output vsync seen");
		end else if (ok) begin
			check_value("raster hsync pulses", 32'(OUT_LINES), 32'(hs_pulses));
			check_value("raster vsync lines", 32'(VSYNC_LINES), 32'(vs_lines));
			check_value("raster active lines", 32'(ACTIVE_LINES), 32'(active_lines));
		end
		finish_test("raster");
	endtask

	task automatic test_gradient();
		logic                    ok;
		video_pkg::pattern_cfg_t pcfg;
		pcfg.mode   = video_pkg::MODE_GRADIENT;
		pcfg.colour = '0;
		wait_edge(SEL_VSYNC, 1'b1, 2 * FRAME_CLOCKS, "output vsync", ok);
		if (ok) begin
			check_frame("gradient", pcfg);
		end
		finish_test("gradient");
	endtask

	task automatic test_handshake();
		logic                    ok;
		video_pkg::pattern_cfg_t pcfg;
		pcfg.mode   = video_pkg::MODE_GRADIENT;
		pcfg.colour = '0;
		load_config("handshake", pcfg, ok);
		// No new ack without a new request
		repeat (ok ? 20 : 0) begin
			step();
			check_value("handshake ack idle", 32'd0, 32'(cfg_ack));
		end
		finish_test("handshake");
	endtask

	// Random colour, then one full frame in that mode
	task automatic test_mode(string name, logic [1:0] mode);
		logic                    ok;
		video_pkg::pattern_cfg_t pcfg;
		rng_state   = xorshift32(rng_state);
		pcfg.mode   = mode;
		pcfg.colour = rng_state[11:0];
		load_config(name, pcfg, ok);
		if (ok) begin
			check_frame(name, pcfg);
		end
		finish_test(name);
	endtask

	////////////////////////////////////////////////////////////
	// Sequence
	////////////////////////////////////////////////////////////

	initial begin
		arst_n          = 1'b0;
		cfg_req         = 1'b0;
		cfg             = '0;
		error_count     = 0;
		errors_at_start = 0;
		test_count      = 0;
		rng_state       = SEED;
		test_reset();
		test_raster();
		test_gradient();
		test_handshake();
		test_mode("solid", video_pkg::MODE_SOLID);
		test_mode("checker", video_pkg::MODE_CHECKER);
		$display("%0d tests run, %0d errors", test_count, error_count);
		if (error_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule
